//--- riscv_pkg.sv
// widths, opcodes and enums for the rv32i subset pipeline
// stage payload structs and the data bus request
package riscv_pkg;

    // ==================================================
    // widths and constants
    // ==================================================
    localparam int XLEN      = 32;
    localparam int REG_COUNT = 32;

    typedef logic [XLEN-1:0]              word_t;
    typedef logic [$clog2(REG_COUNT)-1:0] reg_addr_t;

    localparam word_t RESET_PC  = '0;
    localparam word_t NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

    // major opcodes, instr[6:0]
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011; // only ecall, used as halt

    // ==================================================
    // selects
    // ==================================================
    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU, WB_MEM, WB_PC4
    } wb_sel_e;

    // where an execute operand comes from
    typedef enum logic [2:0] {
        FWD_NONE,   // value read in decode
        FWD_ALU_M,  // alu result sitting in memory stage
        FWD_MEM_M,  // load data, straight off the data bus
        FWD_PC4_M,  // link value of a jump in memory stage
        FWD_WB      // writeback data
    } fwd_sel_e;

    // ==================================================
    // stage payloads
    // ==================================================
    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;   // operand b is the immediate
        logic    branch_eq;
        logic    jump;      // jal or jalr
        logic    is_jalr;   // target from alu sum
        logic    mem_wr;
        wb_sel_e wb_sel;
        logic    reg_wr;
        logic    halt;
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     pc;
        word_t     imm;
        word_t     rs1_data;
        word_t     rs2_data;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
    } id_ex_t;

    typedef struct packed {
        word_t     alu_result; // also the data address
        word_t     store_data;
        reg_addr_t rd;
        word_t     pc4;
        logic      mem_wr;
        wb_sel_e   wb_sel;
        logic      reg_wr;
        logic      halt;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_wr;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

    typedef struct packed {
        word_t addr;  // byte address
        word_t wdata;
        logic  wr;
    } dbus_req_t;

endpackage

//--- fetch_stage.sv
// fetch stage: program counter and the fetch/decode register
`timescale 1ns/1ps

module fetch_stage (
    input  logic             clk,
    input  logic             reset,
    input  logic             redirect,  // taken branch or jump from execute
    input  riscv_pkg::word_t target,
    output riscv_pkg::word_t imem_addr,
    input  riscv_pkg::word_t imem_data, // combinational, same cycle
    output riscv_pkg::word_t instr_d,
    output riscv_pkg::word_t pc_d
);

    riscv_pkg::word_t pc;
    riscv_pkg::word_t pc_next;

    assign imem_addr = pc;
    assign pc_next   = redirect ? target : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= riscv_pkg::RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // fetch/decode register, the word fetched under a redirect is squashed
    always_ff @(posedge clk) begin
        if (reset || redirect) begin
            instr_d <= riscv_pkg::NOP_INSTR;
            pc_d    <= '0;
        end else begin
            instr_d <= imem_data;
            pc_d    <= pc;
        end
    end

    // redirect targets come from execute and must keep the pc on word boundaries
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

//--- reg_file.sv
// 32 x 32 register file, x0 hardwired, writeback bypass on read
`timescale 1ns/1ps

module reg_file (
    input  logic                 clk,
    input  logic                 reset,
    input  riscv_pkg::reg_addr_t rs1,
    input  riscv_pkg::reg_addr_t rs2,
    output riscv_pkg::word_t     rs1_data,
    output riscv_pkg::word_t     rs2_data,
    input  riscv_pkg::wb_t       wb
);

    riscv_pkg::word_t regs [riscv_pkg::REG_COUNT];
    logic             wb_live;  // a real write this cycle

    assign wb_live = wb.reg_wr && (wb.rd != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < riscv_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_live) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // writer three ahead of the reader lands here in the same cycle
    assign rs1_data = (rs1 == '0) ? '0 : (wb_live && wb.rd == rs1) ? wb.data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : (wb_live && wb.rd == rs2) ? wb.data : regs[rs2];

    a_x0_zero: assert property (@(posedge clk) disable iff (reset) regs[0] == '0);

endmodule

//--- decode_stage.sv
// decode stage: control decode, immediates, register read
// and the decode/execute register
`timescale 1ns/1ps

module decode_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  riscv_pkg::word_t     instr,
    input  riscv_pkg::word_t     pc,
    input  logic                 flush,  // taken redirect in execute
    input  riscv_pkg::wb_t       wb,
    output riscv_pkg::reg_addr_t rs1,
    output riscv_pkg::reg_addr_t rs2,
    output riscv_pkg::id_ex_t    id_ex
);

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    riscv_pkg::reg_addr_t rd;
    riscv_pkg::ctrl_t     ctrl;
    riscv_pkg::word_t     imm;
    riscv_pkg::word_t     rs1_data;
    riscv_pkg::word_t     rs2_data;

    // funct3 to alu op, sub only for r-type with funct7[5]
    function automatic riscv_pkg::alu_op_e alu_from_funct(input logic [2:0] f3,
                                                          input logic       sub);
        case (f3)
            3'b000:  return sub ? riscv_pkg::ALU_SUB : riscv_pkg::ALU_ADD;
            3'b010:  return riscv_pkg::ALU_SLT;
            3'b011:  return riscv_pkg::ALU_SLTU;
            3'b100:  return riscv_pkg::ALU_XOR;
            3'b110:  return riscv_pkg::ALU_OR;
            3'b111:  return riscv_pkg::ALU_AND;
            default: return riscv_pkg::ALU_ADD; // shifts not supported
        endcase
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // ==================================================
    // control decode
    // ==================================================
    always_comb begin
        ctrl = '0;  // unknown opcode falls out as a nop
        case (opcode)
            riscv_pkg::OP_REG: begin
                ctrl.alu_op = alu_from_funct(funct3, instr[30]);
                ctrl.reg_wr = 1'b1;
            end
            riscv_pkg::OP_IMM: begin
                ctrl.alu_op  = alu_from_funct(funct3, 1'b0);
                ctrl.use_imm = 1'b1;
                ctrl.reg_wr  = 1'b1;
            end
            riscv_pkg::OP_LOAD: begin
                ctrl.use_imm = 1'b1;            // address = rs1 + imm
                ctrl.wb_sel  = riscv_pkg::WB_MEM;
                ctrl.reg_wr  = 1'b1;
            end
            riscv_pkg::OP_STORE: begin
                ctrl.use_imm = 1'b1;
                ctrl.mem_wr  = 1'b1;
            end
            riscv_pkg::OP_BRANCH: begin
                ctrl.alu_op    = riscv_pkg::ALU_SUB; // zero result means equal
                ctrl.branch_eq = (funct3 == 3'b000);
            end
            riscv_pkg::OP_JAL: begin
                ctrl.jump   = 1'b1;
                ctrl.wb_sel = riscv_pkg::WB_PC4;
                ctrl.reg_wr = 1'b1;
            end
            riscv_pkg::OP_JALR: begin
                ctrl.jump    = 1'b1;
                ctrl.is_jalr = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.wb_sel  = riscv_pkg::WB_PC4;
                ctrl.reg_wr  = 1'b1;
            end
            riscv_pkg::OP_SYSTEM: ctrl.halt = 1'b1;
            default: ;
        endcase
    end

    // immediate generator, i-type unless the format says otherwise
    always_comb begin
        case (opcode)
            riscv_pkg::OP_STORE:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            riscv_pkg::OP_BRANCH:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            riscv_pkg::OP_JAL:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    reg_file i_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    // ==================================================
    // decode/execute register
    // ==================================================
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            id_ex <= '0; // nop bundle, all control low
        end else begin
            id_ex.ctrl     <= ctrl;
            id_ex.pc       <= pc;
            id_ex.imm      <= imm;
            id_ex.rs1_data <= rs1_data;
            id_ex.rs2_data <= rs2_data;
            id_ex.rs1      <= rs1;
            id_ex.rs2      <= rs2;
            id_ex.rd       <= rd;
        end
    end

endmodule

//--- forward_unit.sv
// hazard detection and operand source select for execute
`timescale 1ns/1ps

module forward_unit (
    input  riscv_pkg::reg_addr_t rs1_e,
    input  riscv_pkg::reg_addr_t rs2_e,
    input  riscv_pkg::ex_mem_t   ex_mem,
    input  riscv_pkg::wb_t       wb,
    output riscv_pkg::fwd_sel_e  fwd_a,
    output riscv_pkg::fwd_sel_e  fwd_b
);

    // youngest producer wins, memory stage ahead of writeback
    function automatic riscv_pkg::fwd_sel_e pick(input riscv_pkg::reg_addr_t rs,
                                                 input riscv_pkg::ex_mem_t   mem,
                                                 input riscv_pkg::wb_t       w);
        if (mem.reg_wr && mem.rd != '0 && mem.rd == rs) begin
            case (mem.wb_sel)
                riscv_pkg::WB_MEM: return riscv_pkg::FWD_MEM_M;
                riscv_pkg::WB_PC4: return riscv_pkg::FWD_PC4_M;
                default:           return riscv_pkg::FWD_ALU_M;
            endcase
        end else if (w.reg_wr && w.rd != '0 && w.rd == rs) begin
            return riscv_pkg::FWD_WB;
        end
        return riscv_pkg::FWD_NONE;
    endfunction

    assign fwd_a = pick(rs1_e, ex_mem, wb);
    assign fwd_b = pick(rs2_e, ex_mem, wb);

endmodule

//--- execute_stage.sv
// execute stage: operand forwarding, alu, branch/jump resolution
// and the execute/memory register
`timescale 1ns/1ps

module execute_stage (
    input  logic                clk,
    input  logic                reset,
    input  riscv_pkg::id_ex_t   id_ex,
    input  riscv_pkg::fwd_sel_e fwd_a,
    input  riscv_pkg::fwd_sel_e fwd_b,
    input  riscv_pkg::word_t    mem_rdata,  // load data, combinational
    input  riscv_pkg::wb_t      wb,
    output riscv_pkg::ex_mem_t  ex_mem,
    output logic                redirect,
    output riscv_pkg::word_t    target
);

    riscv_pkg::word_t op_a;
    riscv_pkg::word_t rs2_fwd;    // also the store data
    riscv_pkg::word_t op_b;
    riscv_pkg::word_t alu_result;
    riscv_pkg::word_t pc4;
    logic             zero;

    function automatic riscv_pkg::word_t pick_operand(input riscv_pkg::fwd_sel_e sel,
                                                      input riscv_pkg::word_t    reg_val,
                                                      input riscv_pkg::ex_mem_t  mem,
                                                      input riscv_pkg::word_t    rdata,
                                                      input riscv_pkg::word_t    wb_data);
        case (sel)
            riscv_pkg::FWD_ALU_M: return mem.alu_result;
            riscv_pkg::FWD_MEM_M: return rdata;
            riscv_pkg::FWD_PC4_M: return mem.pc4;
            riscv_pkg::FWD_WB:    return wb_data;
            default:              return reg_val;
        endcase
    endfunction

    // ex_mem is this stage's own output, i.e. the instruction now in memory
    assign op_a    = pick_operand(fwd_a, id_ex.rs1_data, ex_mem, mem_rdata, wb.data);
    assign rs2_fwd = pick_operand(fwd_b, id_ex.rs2_data, ex_mem, mem_rdata, wb.data);
    assign op_b    = id_ex.ctrl.use_imm ? id_ex.imm : rs2_fwd;
    assign pc4     = id_ex.pc + 32'd4;

    // ==================================================
    // alu
    // ==================================================
    always_comb begin
        case (id_ex.ctrl.alu_op)
            riscv_pkg::ALU_SUB:  alu_result = op_a - op_b;
            riscv_pkg::ALU_AND:  alu_result = op_a & op_b;
            riscv_pkg::ALU_OR:   alu_result = op_a | op_b;
            riscv_pkg::ALU_XOR:  alu_result = op_a ^ op_b;
            riscv_pkg::ALU_SLT:  alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            riscv_pkg::ALU_SLTU: alu_result = {31'd0, op_a < op_b};
            default:             alu_result = op_a + op_b;
        endcase
    end

    assign zero = (alu_result == '0);

    // branch and jump resolution
    assign redirect = id_ex.ctrl.jump || (id_ex.ctrl.branch_eq && zero);
    assign target   = id_ex.ctrl.is_jalr ? {alu_result[31:1], 1'b0} // jalr, rs1 + imm
                                         : id_ex.pc + id_ex.imm;     // beq and jal

    // execute/memory register
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem <= '0;
        end else begin
            ex_mem.alu_result <= alu_result;
            ex_mem.store_data <= rs2_fwd;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.pc4        <= pc4;
            ex_mem.mem_wr     <= id_ex.ctrl.mem_wr;
            ex_mem.wb_sel     <= id_ex.ctrl.wb_sel;
            ex_mem.reg_wr     <= id_ex.ctrl.reg_wr;
            ex_mem.halt       <= id_ex.ctrl.halt;
        end
    end

endmodule

//--- mem_wb_stage.sv
// memory stage bus drive, memory/writeback register and writeback select
`timescale 1ns/1ps

module mem_wb_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  riscv_pkg::ex_mem_t    ex_mem,
    output riscv_pkg::dbus_req_t  dbus,
    input  riscv_pkg::word_t      dbus_rdata, // combinational read for dbus.addr
    output riscv_pkg::word_t      mem_rdata,
    output riscv_pkg::wb_t        wb,
    output logic                  halt
);

    riscv_pkg::wb_t wb_next;

    assign dbus.addr  = ex_mem.alu_result;
    assign dbus.wdata = ex_mem.store_data;
    assign dbus.wr    = ex_mem.mem_wr;
    assign mem_rdata  = dbus_rdata;  // feeds the load forward into execute

    // writeback data select
    always_comb begin
        wb_next.reg_wr = ex_mem.reg_wr;
        wb_next.rd     = ex_mem.rd;
        case (ex_mem.wb_sel)
            riscv_pkg::WB_MEM: wb_next.data = dbus_rdata;
            riscv_pkg::WB_PC4: wb_next.data = ex_mem.pc4;  // jump link
            default:           wb_next.data = ex_mem.alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb   <= '0;
            halt <= 1'b0;
        end else begin
            wb   <= wb_next;
            halt <= ex_mem.halt; // ecall now in writeback
        end
    end

    // decode must never mark a store as a register writer
    a_store_no_regwr: assert property (@(posedge clk) disable iff (reset)
        !(dbus.wr && ex_mem.reg_wr));

endmodule

//--- riscv_core.sv
// five stage rv32i subset core, harvard buses and halt
`timescale 1ns/1ps

module riscv_core (
    input  logic                 clk,
    input  logic                 reset,
    output riscv_pkg::word_t     imem_addr,
    input  riscv_pkg::word_t     imem_data,
    output riscv_pkg::dbus_req_t dbus,
    input  riscv_pkg::word_t     dbus_rdata,
    output logic                 halt
);

    logic                redirect;  // also the decode flush
    riscv_pkg::word_t    target;
    riscv_pkg::word_t    instr_d;
    riscv_pkg::word_t    pc_d;
    riscv_pkg::id_ex_t   id_ex;
    riscv_pkg::ex_mem_t  ex_mem;
    riscv_pkg::fwd_sel_e fwd_a;
    riscv_pkg::fwd_sel_e fwd_b;
    riscv_pkg::word_t    mem_rdata;
    riscv_pkg::wb_t      wb;

    // ==================================================
    // stages
    // ==================================================
    fetch_stage i_fetch (
        .clk       (clk),
        .reset     (reset),
        .redirect  (redirect),
        .target    (target),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .instr_d   (instr_d),
        .pc_d      (pc_d)
    );

    decode_stage i_decode (
        .clk   (clk),
        .reset (reset),
        .instr (instr_d),
        .pc    (pc_d),
        .flush (redirect),
        .wb    (wb),
        .rs1   (),
        .rs2   (),
        .id_ex (id_ex)
    );

    // operand sources for the instruction in execute
    forward_unit i_forward (
        .rs1_e  (id_ex.rs1),
        .rs2_e  (id_ex.rs2),
        .ex_mem (ex_mem),
        .wb     (wb),
        .fwd_a  (fwd_a),
        .fwd_b  (fwd_b)
    );

    execute_stage i_execute (
        .clk       (clk),
        .reset     (reset),
        .id_ex     (id_ex),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b),
        .mem_rdata (mem_rdata),
        .wb        (wb),
        .ex_mem    (ex_mem),
        .redirect  (redirect),
        .target    (target)
    );

    mem_wb_stage i_mem_wb (
        .clk        (clk),
        .reset      (reset),
        .ex_mem     (ex_mem),
        .dbus       (dbus),
        .dbus_rdata (dbus_rdata),
        .mem_rdata  (mem_rdata),
        .wb         (wb),
        .halt       (halt)
    );

endmodule

//--- tb_riscv_core.sv
// testbench for riscv_core: clock, reset, memory models, test table,
// store and count checks, watchdog
`timescale 1ns/1ps

module tb_riscv_core;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_TESTS  = 6;
    localparam int MAX_WORDS  = 16;
    localparam int MAX_STORES = 4;
    localparam int TEST_CYCLES = 80;  // budget per test for the watchdog
    localparam riscv_pkg::word_t ECALL = 32'h0000_0073;

    logic                 clk;
    logic                 reset;
    riscv_pkg::word_t     imem_addr;
    riscv_pkg::word_t     imem_data;
    riscv_pkg::dbus_req_t dbus;
    riscv_pkg::word_t     dbus_rdata;
    logic                 halt;

    riscv_pkg::word_t imem [64];
    riscv_pkg::word_t dmem [64] = '{default: '0};

    // test table, one row per test
    string                test_name [NUM_TESTS];
    riscv_pkg::word_t     prog      [NUM_TESTS][MAX_WORDS];
    int                   prog_len  [NUM_TESTS];
    riscv_pkg::dbus_req_t exp_store [NUM_TESTS][MAX_STORES];  // program order
    int                   exp_count [NUM_TESTS];
    int                   exp_halt  [NUM_TESTS];  // negedges from reset release to halt

    int errors;

    riscv_core i_dut (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dbus       (dbus),
        .dbus_rdata (dbus_rdata),
        .halt       (halt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==================================================
    // memory models, both read combinationally
    // ==================================================
    assign imem_data  = imem[imem_addr[7:2]];
    assign dbus_rdata = dmem[dbus.addr[7:2]];

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i] <= '0;  // fresh data memory per test
            end
        end else if (dbus.wr) begin
            dmem[dbus.addr[7:2]] <= dbus.wdata;
        end
    end

    // ==================================================
    // instruction encoders
    // ==================================================
    function automatic riscv_pkg::word_t rtype(input int f7, input int f3, input int rd,
                                               input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], riscv_pkg::OP_REG};
    endfunction

    function automatic riscv_pkg::word_t itype(input int f3, input int rd, input int rs1,
                                               input int imm, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic riscv_pkg::word_t addi(input int rd, input int rs1, input int imm);
        return itype(0, rd, rs1, imm, riscv_pkg::OP_IMM);
    endfunction

    function automatic riscv_pkg::word_t sw(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], riscv_pkg::OP_STORE};
    endfunction

    function automatic riscv_pkg::word_t lw(input int rd, input int rs1, input int imm);
        return itype(2, rd, rs1, imm, riscv_pkg::OP_LOAD);
    endfunction

    function automatic riscv_pkg::word_t beq(input int rs1, input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000, off[4:1], off[11],
                riscv_pkg::OP_BRANCH};
    endfunction

    function automatic riscv_pkg::word_t jal(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], riscv_pkg::OP_JAL};
    endfunction

    function automatic riscv_pkg::word_t jalr(input int rd, input int rs1, input int imm);
        return itype(0, rd, rs1, imm, riscv_pkg::OP_JALR);
    endfunction

    task automatic put_instr(input int t, input riscv_pkg::word_t w);
        prog[t][prog_len[t]] = w;
        prog_len[t]++;
    endtask

    task automatic expect_store(input int t, input riscv_pkg::word_t addr,
                                input riscv_pkg::word_t data);
        riscv_pkg::dbus_req_t req;
        req.addr  = addr;
        req.wdata = data;
        req.wr    = 1'b1;
        exp_store[t][exp_count[t]] = req;
        exp_count[t]++;
    endtask

    // ==================================================
    // test table, expected values worked out by hand
    // ==================================================
    task automatic load_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            prog_len[t]  = 0;
            exp_count[t] = 0;
        end
        test_name[0] = "alu_forward";
        put_instr(0, addi(1, 0, 5));           // x1 = 5
        put_instr(0, addi(2, 1, -8));          // x2 = -3, x1 from memory stage
        put_instr(0, rtype(0, 0, 3, 1, 2));    // add  x3 = 2
        put_instr(0, rtype(32, 0, 4, 3, 1));   // sub  x4 = -3
        put_instr(0, rtype(0, 7, 5, 4, 2));    // and  x5 = fffffffd
        put_instr(0, rtype(0, 6, 6, 5, 1));    // or   x6 = fffffffd
        put_instr(0, rtype(0, 4, 7, 6, 3));    // xor  x7 = ffffffff
        put_instr(0, rtype(0, 2, 8, 7, 1));    // slt  -1 < 5 signed
        put_instr(0, rtype(0, 3, 9, 7, 1));    // sltu, false unsigned
        put_instr(0, sw(9, 0, 12));            // x9 straight from memory stage
        put_instr(0, sw(8, 0, 8));             // x8 from writeback
        put_instr(0, sw(7, 0, 4));
        put_instr(0, sw(3, 0, 0));
        put_instr(0, ECALL);
        expect_store(0, 32'h0c, 32'h0);
        expect_store(0, 32'h08, 32'h1);
        expect_store(0, 32'h04, 32'hffff_ffff);
        expect_store(0, 32'h00, 32'h2);
        exp_halt[0] = 17;  // ecall at word 13, four stages later

        test_name[1] = "load_store";
        put_instr(1, addi(1, 0, 100));
        put_instr(1, addi(2, 0, 23));
        put_instr(1, sw(1, 0, 32'h20));
        put_instr(1, lw(3, 0, 32'h20));
        put_instr(1, rtype(0, 0, 4, 3, 2));    // uses load data the next cycle
        put_instr(1, sw(4, 0, 32'h24));
        put_instr(1, ECALL);
        expect_store(1, 32'h20, 32'd100);
        expect_store(1, 32'h24, 32'd123);
        exp_halt[1] = 10;

        test_name[2] = "beq";
        put_instr(2, addi(1, 0, 7));
        put_instr(2, addi(2, 0, 7));
        put_instr(2, beq(1, 2, 12));           // taken, to word 5
        put_instr(2, sw(1, 0, 0));             // flushed
        put_instr(2, sw(2, 0, 4));             // flushed
        put_instr(2, sw(1, 0, 8));
        put_instr(2, addi(3, 0, 1));
        put_instr(2, beq(3, 0, 12));           // not taken
        put_instr(2, sw(3, 0, 12));
        put_instr(2, ECALL);
        expect_store(2, 32'h08, 32'd7);
        expect_store(2, 32'h0c, 32'd1);
        exp_halt[2] = 13;

        test_name[3] = "jumps";
        put_instr(3, jal(1, 12));              // link 4, to 0x0c
        put_instr(3, sw(0, 0, 0));
        put_instr(3, sw(0, 0, 4));
        put_instr(3, sw(1, 0, 8));
        put_instr(3, addi(2, 0, 32'h20));
        put_instr(3, jalr(3, 2, 4));           // to 0x24, link 0x18
        put_instr(3, sw(0, 0, 12));
        put_instr(3, sw(0, 0, 16));
        put_instr(3, sw(0, 0, 20));            // never fetched
        put_instr(3, sw(3, 0, 24));
        put_instr(3, ECALL);
        expect_store(3, 32'h08, 32'h04);
        expect_store(3, 32'h18, 32'h18);
        exp_halt[3] = 13;  // jalr skips one fetch slot

        test_name[4] = "bypass_x0_imm";
        put_instr(4, addi(1, 0, 32'h55));
        put_instr(4, addi(0, 0, 0));
        put_instr(4, addi(0, 0, 0));
        put_instr(4, sw(1, 0, 0));             // reader three behind the writer
        put_instr(4, addi(0, 0, 9));           // discarded
        put_instr(4, sw(0, 0, 4));
        put_instr(4, itype(7, 2, 1, 32'h0f, riscv_pkg::OP_IMM)); // andi -> 5
        put_instr(4, itype(6, 3, 2, 32'h30, riscv_pkg::OP_IMM)); // ori  -> 0x35
        put_instr(4, itype(4, 4, 3, -1, riscv_pkg::OP_IMM));     // xori -> ffffffca
        put_instr(4, itype(2, 5, 4, 0, riscv_pkg::OP_IMM));      // slti, negative
        put_instr(4, itype(3, 6, 4, 32'h10, riscv_pkg::OP_IMM)); // sltiu, large
        put_instr(4, sw(4, 0, 8));
        put_instr(4, rtype(32, 0, 7, 5, 6));   // 1 - 0
        put_instr(4, sw(7, 0, 12));
        put_instr(4, ECALL);
        expect_store(4, 32'h00, 32'h55);
        expect_store(4, 32'h04, 32'h0);
        expect_store(4, 32'h08, 32'hffff_ffca);
        expect_store(4, 32'h0c, 32'h1);
        exp_halt[4] = 18;

        test_name[5] = "nop_halt";
        for (int i = 0; i < 8; i++) begin
            put_instr(5, addi(0, 0, 0));
        end
        put_instr(5, ECALL);
        exp_halt[5] = 12;  // halt stays low until then, no stores
    endtask

    // ==================================================
    // checks
    // ==================================================
    task automatic check_store(input string name, input int idx,
                               input riscv_pkg::dbus_req_t exp,
                               input riscv_pkg::dbus_req_t got);
        if (got !== exp) begin
            errors++;
            $display("** Error %s store %0d: expected addr=%h wdata=%h, actual addr=%h wdata=%h",
                     name, idx, exp.addr, exp.wdata, got.addr, got.wdata);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int got);
        if (got != exp) begin
            errors++;
            $display("** Error %s: expected %0d, actual %0d", name, exp, got);
        end
    endtask

    // reset, load memories, run to halt and compare the stores
    task automatic run_test(input int t);
        riscv_pkg::dbus_req_t got [$];
        int cycles;
        int n;
        reset = 1'b1;
        for (int i = 0; i < 64; i++) begin
            imem[i] = addi(0, 0, i);  // harmless filler, tagged by word index
        end
        for (int i = 0; i < prog_len[t]; i++) begin
            imem[i] = prog[t][i];
        end
        repeat (3) @(negedge clk);
        reset  = 1'b0;
        cycles = 0;
        while (halt !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (dbus.wr === 1'b1) begin
                got.push_back(dbus);
            end
        end
        check_count({test_name[t], " halt cycle"}, exp_halt[t], cycles);
        check_count({test_name[t], " store count"}, exp_count[t], got.size());
        n = (got.size() < exp_count[t]) ? got.size() : exp_count[t];
        for (int i = 0; i < n; i++) begin
            check_store(test_name[t], i, exp_store[t][i], got[i]);
        end
    endtask

    initial begin
        reset  = 1'b1;
        errors = 0;
        load_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("tests run: %0d, errors: %0d", NUM_TESTS, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog, a stuck pipeline never raises halt
    initial begin
        #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("timeout: halt was not seen within %0d cycles per test", TEST_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- list.f
riscv_pkg.sv
fetch_stage.sv
reg_file.sv
decode_stage.sv
forward_unit.sv
execute_stage.sv
mem_wb_stage.sv
riscv_core.sv
tb_riscv_core.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = tb_riscv_core
FILELIST = list.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '>>> PASS'

clean:
	rm -rf obj_dir
